/* rtl/csb_pkg.sv */
package csb_pkg;

    // One layer command is a burst of eight 32-bit words
    localparam int CMD_BURST_LEN = 8;
    localparam int CMD_WORD_W    = 32;

    // Word position inside a command burst, 0 to 7
    typedef logic [2:0] word_idx_t;

    // Sequencer states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        // Burst read of one command
        ST_CMD_GET   = 3'd1,
        // Single cycle, engine start
        ST_CMD_ISSUE = 3'd2,
        // Waiting for engine done
        ST_OP_RUN    = 3'd3,
        // All commands done, irq raised
        ST_FINISH    = 3'd4
    } state_t;

    // Layer op types from word 0 bits 2:0
    localparam logic [2:0] OP_IDLE      = 3'b000;
    localparam logic [2:0] OP_CONV_RELU = 3'b001;
    localparam logic [2:0] OP_MAX_POOL  = 3'b100;
    localparam logic [2:0] OP_AVG_POOL  = 3'b101;

endpackage

/* rtl/cmd_fetch.sv */
`timescale 1ns/1ps

module cmd_fetch #(
    parameter int ADDR_W = 30
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_fetch_en,
    input  logic                 i_cmd_we,
    output logic                 o_cmd_rd_en,
    output logic [ADDR_W-1:0]    o_cmd_addr,
    output logic                 o_word_stb,
    output csb_pkg::word_idx_t   o_word_idx,
    output logic                 o_burst_done
);

    // Index of the final word in a burst
    localparam csb_pkg::word_idx_t LAST_IDX = csb_pkg::word_idx_t'(csb_pkg::CMD_BURST_LEN - 1);

    csb_pkg::word_idx_t word_cnt;

    // Words seen while the read enable is low are dropped
    assign o_word_stb   = i_cmd_we && o_cmd_rd_en;
    assign o_word_idx   = word_cnt;
    assign o_burst_done = o_word_stb && (word_cnt == LAST_IDX);

    // Read enable follows fetch enable by one cycle
    // and drops right after the last word is taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_cmd_rd_en <= 1'b0;
        end else begin
            o_cmd_rd_en <= i_fetch_en && !o_burst_done;
        end
    end

    // Burst counter, reloaded whenever fetch is idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_cnt <= '0;
        end else if (!i_fetch_en) begin
            word_cnt <= '0;
        end else if (o_word_stb) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // Running byte address over all commands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_cmd_addr <= '0;
        end else if (o_word_stb) begin
            o_cmd_addr <= o_cmd_addr + ADDR_W'(4);
        end
    end

endmodule

/* rtl/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode #(
    parameter int ADDR_W = 30
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_word_stb,
    input  csb_pkg::word_idx_t                i_word_idx,
    input  logic [csb_pkg::CMD_WORD_W-1:0]    i_cmd_word,
    output logic [2:0]                        o_op_type,
    output logic [3:0]                        o_stride,
    output logic [7:0]                        o_kernel,
    output logic [7:0]                        o_i_side,
    output logic [7:0]                        o_o_side,
    output logic [15:0]                       o_i_channel,
    output logic [15:0]                       o_o_channel,
    output logic [1:0]                        o_result_mask,
    output logic [7:0]                        o_kernel_size,
    output logic [15:0]                       o_stride2,
    output logic [ADDR_W-1:0]                 o_weight_addr,
    output logic [ADDR_W-1:0]                 o_data_addr,
    output logic [ADDR_W-1:0]                 o_p0_addr,
    output logic [ADDR_W-1:0]                 o_p1_addr,
    output logic [7:0]                        o_p0_pad_head,
    output logic [7:0]                        o_p0_pad_body,
    output logic [7:0]                        o_p1_pad_head,
    output logic [7:0]                        o_p1_pad_body
);

    // Each word updates only its own fields
    // Fields hold until the same word of the next burst
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_op_type     <= '0;
            o_stride      <= '0;
            o_kernel      <= '0;
            o_i_side      <= '0;
            o_o_side      <= '0;
            o_i_channel   <= '0;
            o_o_channel   <= '0;
            o_result_mask <= '0;
            o_kernel_size <= '0;
            o_stride2     <= '0;
            o_weight_addr <= '0;
            o_data_addr   <= '0;
            o_p0_addr     <= '0;
            o_p1_addr     <= '0;
            o_p0_pad_head <= '0;
            o_p0_pad_body <= '0;
            o_p1_pad_head <= '0;
            o_p1_pad_body <= '0;
        end else if (i_word_stb) begin
            case (i_word_idx)
                // Op type and geometry, bit 3 unused
                3'd0: begin
                    o_op_type <= i_cmd_word[2:0];
                    o_stride  <= i_cmd_word[7:4];
                    o_kernel  <= i_cmd_word[15:8];
                    o_i_side  <= i_cmd_word[23:16];
                    o_o_side  <= i_cmd_word[31:24];
                end
                3'd1: begin
                    o_i_channel <= i_cmd_word[15:0];
                    o_o_channel <= i_cmd_word[31:16];
                end
                // Mask, kernel size and kernel times stride
                3'd2: begin
                    o_result_mask <= i_cmd_word[1:0];
                    o_kernel_size <= i_cmd_word[15:8];
                    o_stride2     <= i_cmd_word[31:16];
                end
                3'd3: o_weight_addr <= i_cmd_word[ADDR_W-1:0];
                3'd4: o_data_addr   <= i_cmd_word[ADDR_W-1:0];
                3'd5: o_p0_addr     <= i_cmd_word[ADDR_W-1:0];
                3'd6: o_p1_addr     <= i_cmd_word[ADDR_W-1:0];
                // Padding bytes, low byte first
                default: begin
                    o_p0_pad_head <= i_cmd_word[7:0];
                    o_p0_pad_body <= i_cmd_word[15:8];
                    o_p1_pad_head <= i_cmd_word[23:16];
                    o_p1_pad_body <= i_cmd_word[31:24];
                end
            endcase
        end
    end

endmodule

/* rtl/csb_ctrl.sv */
`timescale 1ns/1ps

module csb_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_op_en,
    input  logic [6:0]        i_cmd_count,
    input  logic              i_burst_done,
    input  logic              i_eng_done,
    output logic              o_fetch_en,
    output logic              o_eng_start,
    output logic              o_engine_valid,
    output logic              o_engine_reset,
    output csb_pkg::state_t   o_state,
    output logic [6:0]        o_done_count,
    output logic              o_irq
);

    csb_pkg::state_t state;
    csb_pkg::state_t state_nxt;
    logic            last_cmd;
    logic            eng_active;

    // True when the command now finishing is the last one
    assign last_cmd = (o_done_count + 7'd1) == i_cmd_count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= csb_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            csb_pkg::ST_IDLE: begin
                if (i_op_en) begin
                    state_nxt = csb_pkg::ST_CMD_GET;
                end
            end
            csb_pkg::ST_CMD_GET: begin
                if (i_burst_done) begin
                    state_nxt = csb_pkg::ST_CMD_ISSUE;
                end
            end
            // Issue always lasts a single cycle
            csb_pkg::ST_CMD_ISSUE: begin
                state_nxt = csb_pkg::ST_OP_RUN;
            end
            csb_pkg::ST_OP_RUN: begin
                if (i_eng_done) begin
                    state_nxt = last_cmd ? csb_pkg::ST_FINISH : csb_pkg::ST_CMD_GET;
                end
            end
            csb_pkg::ST_FINISH: begin
                state_nxt = csb_pkg::ST_FINISH;
            end
            default: begin
                state_nxt = csb_pkg::ST_IDLE;
            end
        endcase
    end

    // Completed command count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_done_count <= '0;
        end else if (state == csb_pkg::ST_OP_RUN && i_eng_done) begin
            o_done_count <= o_done_count + 7'd1;
        end
    end

    // Interrupt one cycle into finish, sticky until reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_irq <= 1'b0;
        end else if (state == csb_pkg::ST_FINISH) begin
            o_irq <= 1'b1;
        end
    end

    // Engine is live from issue until its done pulse
    assign eng_active = (state == csb_pkg::ST_CMD_ISSUE) || (state == csb_pkg::ST_OP_RUN);

    assign o_fetch_en     = (state == csb_pkg::ST_CMD_GET);
    assign o_eng_start    = (state == csb_pkg::ST_CMD_ISSUE);
    assign o_engine_valid = eng_active;
    assign o_engine_reset = !eng_active;
    assign o_state        = state;

endmodule

/* rtl/result_wr_engine.sv */
`timescale 1ns/1ps

module result_wr_engine #(
    parameter int ADDR_W = 30
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_start,
    input  logic [2:0]           i_op_type,
    input  logic [7:0]           i_o_side,
    input  logic [15:0]          i_o_channel,
    input  logic [1:0]           i_result_mask,
    input  logic [ADDR_W-1:0]    i_p0_addr,
    input  logic [ADDR_W-1:0]    i_p1_addr,
    input  logic                 i_res_stall,
    output logic                 o_res_we,
    output logic                 o_res_port,
    output logic [ADDR_W-1:0]    o_res_addr,
    output logic                 o_done,
    output logic                 o_busy
);

    // Output elements per layer, o_side squared times channels
    logic [31:0]        elem_total;
    logic [31:0]        elem_cnt;
    logic [31:0]        elem_num;
    logic [1:0]         mask_q;
    logic [ADDR_W-1:0]  p0_base;
    logic [ADDR_W-1:0]  p1_base;
    // Byte offset of the current element, 4 per element
    logic [ADDR_W-1:0]  offs;
    logic               port_ph;
    logic               no_beats;
    logic               beat_ok;
    logic               elem_end;

    assign elem_num = i_o_side * i_o_side * i_o_channel;
    assign no_beats = (i_op_type == csb_pkg::OP_IDLE) || (i_result_mask == 2'b00)
                      || (elem_num == 32'd0);

    // A beat is written when not stalled
    assign beat_ok  = o_busy && !i_res_stall;
    // Port 1 beat, or port 0 with port 1 masked off, closes the element
    assign elem_end = port_ph || !mask_q[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_busy  <= 1'b0;
            o_done  <= 1'b0;
            port_ph <= 1'b0;
            mask_q  <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                mask_q <= i_result_mask;
                if (no_beats) begin
                    // Nothing to write, finish straight away
                    o_done <= 1'b1;
                end else begin
                    o_busy  <= 1'b1;
                    port_ph <= !i_result_mask[0];
                end
            end else if (beat_ok) begin
                if (elem_end) begin
                    port_ph <= !mask_q[0];
                    if (elem_cnt == elem_total - 32'd1) begin
                        o_busy <= 1'b0;
                        o_done <= 1'b1;
                    end
                end else begin
                    port_ph <= 1'b1;
                end
            end
        end
    end

    // Counters and latched bases
    always_ff @(posedge clk) begin
        if (i_start) begin
            elem_total <= elem_num;
            elem_cnt   <= '0;
            offs       <= '0;
            p0_base    <= i_p0_addr;
            p1_base    <= i_p1_addr;
        end else if (beat_ok && elem_end) begin
            elem_cnt <= elem_cnt + 32'd1;
            offs     <= offs + ADDR_W'(4);
        end
    end

    // Beat held steady while stalled
    assign o_res_we   = o_busy;
    assign o_res_port = port_ph;
    assign o_res_addr = (port_ph ? p1_base : p0_base) + offs;

endmodule

/* rtl/csb_top.sv */
`timescale 1ns/1ps

module csb_top #(
    parameter int ADDR_W = 30
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_op_en,
    input  logic [6:0]                        i_cmd_count,
    input  logic                              i_cmd_we,
    input  logic [csb_pkg::CMD_WORD_W-1:0]    i_cmd_word,
    input  logic                              i_res_stall,
    output logic                              o_cmd_rd_en,
    output logic [ADDR_W-1:0]                 o_cmd_addr,
    output logic                              o_res_we,
    output logic                              o_res_port,
    output logic [ADDR_W-1:0]                 o_res_addr,
    output logic                              o_irq,
    output csb_pkg::state_t                   o_state,
    output logic                              o_engine_valid,
    output logic                              o_engine_reset,
    // Descriptor fields for the MAC, fetch and padding blocks
    output logic [3:0]                        o_stride,
    output logic [7:0]                        o_kernel,
    output logic [7:0]                        o_i_side,
    output logic [15:0]                       o_i_channel,
    output logic [7:0]                        o_kernel_size,
    output logic [15:0]                       o_stride2,
    output logic [ADDR_W-1:0]                 o_weight_addr,
    output logic [ADDR_W-1:0]                 o_data_addr,
    output logic [7:0]                        o_p0_pad_head,
    output logic [7:0]                        o_p0_pad_body,
    output logic [7:0]                        o_p1_pad_head,
    output logic [7:0]                        o_p1_pad_body
);

    logic                 fetch_en;
    logic                 burst_done;
    logic                 word_stb;
    csb_pkg::word_idx_t   word_idx;
    logic                 eng_start;
    logic                 eng_done;
    // Descriptor fields the engine acts on
    logic [2:0]           op_type;
    logic [7:0]           o_side;
    logic [15:0]          o_channel;
    logic [1:0]           result_mask;
    logic [ADDR_W-1:0]    p0_addr;
    logic [ADDR_W-1:0]    p1_addr;

    csb_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .i_op_en        (i_op_en),
        .i_cmd_count    (i_cmd_count),
        .i_burst_done   (burst_done),
        .i_eng_done     (eng_done),
        .o_fetch_en     (fetch_en),
        .o_eng_start    (eng_start),
        .o_engine_valid (o_engine_valid),
        .o_engine_reset (o_engine_reset),
        .o_state        (o_state),
        .o_done_count   (),
        .o_irq          (o_irq)
    );

    cmd_fetch #(.ADDR_W(ADDR_W)) fetch_i (
        .clk          (clk),
        .rst          (rst),
        .i_fetch_en   (fetch_en),
        .i_cmd_we     (i_cmd_we),
        .o_cmd_rd_en  (o_cmd_rd_en),
        .o_cmd_addr   (o_cmd_addr),
        .o_word_stb   (word_stb),
        .o_word_idx   (word_idx),
        .o_burst_done (burst_done)
    );

    cmd_decode #(.ADDR_W(ADDR_W)) decode_i (
        .clk           (clk),
        .rst           (rst),
        .i_word_stb    (word_stb),
        .i_word_idx    (word_idx),
        .i_cmd_word    (i_cmd_word),
        .o_op_type     (op_type),
        .o_stride      (o_stride),
        .o_kernel      (o_kernel),
        .o_i_side      (o_i_side),
        .o_o_side      (o_side),
        .o_i_channel   (o_i_channel),
        .o_o_channel   (o_channel),
        .o_result_mask (result_mask),
        .o_kernel_size (o_kernel_size),
        .o_stride2     (o_stride2),
        .o_weight_addr (o_weight_addr),
        .o_data_addr   (o_data_addr),
        .o_p0_addr     (p0_addr),
        .o_p1_addr     (p1_addr),
        .o_p0_pad_head (o_p0_pad_head),
        .o_p0_pad_body (o_p0_pad_body),
        .o_p1_pad_head (o_p1_pad_head),
        .o_p1_pad_body (o_p1_pad_body)
    );

    result_wr_engine #(.ADDR_W(ADDR_W)) engine_i (
        .clk           (clk),
        .rst           (rst),
        .i_start       (eng_start),
        .i_op_type     (op_type),
        .i_o_side      (o_side),
        .i_o_channel   (o_channel),
        .i_result_mask (result_mask),
        .i_p0_addr     (p0_addr),
        .i_p1_addr     (p1_addr),
        .i_res_stall   (i_res_stall),
        .o_res_we      (o_res_we),
        .o_res_port    (o_res_port),
        .o_res_addr    (o_res_addr),
        .o_done        (eng_done),
        .o_busy        ()
    );

endmodule

/* bench/csb_chk.sv */
`timescale 1ns/1ps

module csb_chk #(
    parameter int ADDR_W = 30
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_res_we,
    input  logic                i_res_port,
    input  logic [ADDR_W-1:0]   i_res_addr,
    input  logic                i_res_stall,
    input  logic                i_cmd_rd_en,
    input  csb_pkg::state_t     i_state,
    input  logic                i_irq
);

    // Number of failed assertions
    int fail_count = 0;

    // Stalled beat stays on the bus with the same port and address
    property p_stall_hold;
        @(posedge clk) disable iff (rst)
            (i_res_we && i_res_stall) |=>
                (i_res_we && $stable(i_res_port) && $stable(i_res_addr));
    endproperty

    // Command reads only happen while the sequencer fetches
    property p_rd_en_in_get;
        @(posedge clk) disable iff (rst)
            i_cmd_rd_en |-> (i_state == csb_pkg::ST_CMD_GET);
    endproperty

    // Interrupt is sticky until reset
    property p_irq_sticky;
        @(posedge clk) disable iff (rst)
            i_irq |=> i_irq;
    endproperty

    a_stall_hold: assert property (p_stall_hold)
        else begin
            $error("result beat moved or dropped while stalled");
            fail_count++;
        end
    a_rd_en_in_get: assert property (p_rd_en_in_get)
        else begin
            $error("command read enable high outside the fetch state");
            fail_count++;
        end
    a_irq_sticky: assert property (p_irq_sticky)
        else begin
            $error("interrupt fell before reset");
            fail_count++;
        end

endmodule

/* bench/csb_tb.sv */
`timescale 1ns/1ps

module csb_tb;

    localparam int ADDR_W    = 30;
    localparam int NUM_CMDS  = 6;
    localparam int NUM_TESTS = 6;

    logic clk = 1'b0;
    logic rst;
    logic op_en;
    logic [6:0] cmd_count;
    logic cmd_we;
    logic [31:0] cmd_word;
    logic res_stall;
    logic cmd_rd_en;
    logic [ADDR_W-1:0] cmd_addr;
    logic res_we;
    logic res_port;
    logic [ADDR_W-1:0] res_addr;
    logic irq;
    csb_pkg::state_t state;
    logic engine_valid;
    logic engine_reset;
    logic [3:0] stride;
    logic [7:0] kernel;
    logic [7:0] i_side;
    logic [15:0] i_channel;
    logic [7:0] kernel_size;
    logic [15:0] stride2;
    logic [ADDR_W-1:0] weight_addr;
    logic [ADDR_W-1:0] data_addr;
    logic [7:0] p0_pad_head;
    logic [7:0] p0_pad_body;
    logic [7:0] p1_pad_head;
    logic [7:0] p1_pad_body;

    // Command memory model holding eight words per command
    logic [31:0] cmd_mem [0:63];
    logic [31:0] rng;
    // Expected result beats as {port, address}
    logic [ADDR_W:0] exp_q [$];
    int beats_before [0:NUM_CMDS];
    int test_checks [1:NUM_TESTS];
    int test_errs [1:NUM_TESTS];
    string test_name [1:NUM_TESTS];
    int limit_cycles;
    int run_cmds;
    // Monitor state
    logic [ADDR_W-1:0] exp_cmd_addr;
    int words_seen;
    int cmds_issued;
    int beats_written;
    bit irq_seen;
    bit stall_pending;
    logic stall_port;
    logic [ADDR_W-1:0] stall_addr;

    always #50 clk = ~clk;

    csb_top #(.ADDR_W(ADDR_W)) dut_i (
        .clk(clk), .rst(rst), .i_op_en(op_en), .i_cmd_count(cmd_count),
        .i_cmd_we(cmd_we), .i_cmd_word(cmd_word), .i_res_stall(res_stall),
        .o_cmd_rd_en(cmd_rd_en), .o_cmd_addr(cmd_addr), .o_res_we(res_we),
        .o_res_port(res_port), .o_res_addr(res_addr), .o_irq(irq), .o_state(state),
        .o_engine_valid(engine_valid), .o_engine_reset(engine_reset),
        .o_stride(stride), .o_kernel(kernel), .o_i_side(i_side),
        .o_i_channel(i_channel), .o_kernel_size(kernel_size), .o_stride2(stride2),
        .o_weight_addr(weight_addr), .o_data_addr(data_addr),
        .o_p0_pad_head(p0_pad_head), .o_p0_pad_body(p0_pad_body),
        .o_p1_pad_head(p1_pad_head), .o_p1_pad_body(p1_pad_body)
    );

    bind csb_top csb_chk #(.ADDR_W(ADDR_W)) chk_i (
        .clk(clk), .rst(rst), .i_res_we(o_res_we), .i_res_port(o_res_port),
        .i_res_addr(o_res_addr), .i_res_stall(i_res_stall), .i_cmd_rd_en(o_cmd_rd_en),
        .i_state(o_state), .i_irq(o_irq)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_next();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Beats of one command are elements times enabled ports, none for an idle op
    function automatic int cmd_beats(input int c);
        logic [31:0] w0;
        int elems;
        int ports;
        w0 = cmd_mem[c*8];
        elems = int'(w0[31:24]) * int'(w0[31:24]) * int'(cmd_mem[c*8+1][31:16]);
        ports = int'(cmd_mem[c*8+2][0]) + int'(cmd_mem[c*8+2][1]);
        if (w0[2:0] == csb_pkg::OP_IDLE) begin
            return 0;
        end
        return elems * ports;
    endfunction

    task automatic check_value(input int id, input logic [31:0] got,
                               input logic [31:0] exp, input string what);
        test_checks[id]++;
        assert (got == exp) else begin
            test_errs[id]++;
            $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input int id, input bit cond, input string what);
        test_checks[id]++;
        assert (cond) else begin
            test_errs[id]++;
            $display("test %0d went wrong at %0d ns: %s", id, $time, what);
        end
    endtask

    task automatic build_commands();
        logic [31:0] w;
        logic [2:0] op;
        logic [1:0] mask;
        for (int c = 0; c < NUM_CMDS; c++) begin
            w = rand_next();
            case (w[1:0])
                2'd0: op = csb_pkg::OP_IDLE;
                2'd1: op = csb_pkg::OP_CONV_RELU;
                2'd2: op = csb_pkg::OP_MAX_POOL;
                default: op = csb_pkg::OP_AVG_POOL;
            endcase
            mask = w[3:2];
            // Masks 01, 10, 11 and 00 first, then an idle op, last one free
            if (c < 4) begin
                mask = 2'(c + 1);
                if (op == csb_pkg::OP_IDLE) begin
                    op = csb_pkg::OP_MAX_POOL;
                end
            end else if (c == 4) begin
                op = csb_pkg::OP_IDLE;
                mask = 2'b11;
            end
            w = rand_next();
            w[2:0] = op;
            w[31:24] = 8'(1 + rand_next() % 3);
            cmd_mem[c*8] = w;
            w = rand_next();
            w[31:16] = 16'(1 + rand_next() % 2);
            cmd_mem[c*8+1] = w;
            w = rand_next();
            w[1:0] = mask;
            cmd_mem[c*8+2] = w;
            cmd_mem[c*8+3] = rand_next();
            cmd_mem[c*8+4] = rand_next();
            // Result port bases word aligned
            cmd_mem[c*8+5] = rand_next() & 32'hffff_fffc;
            cmd_mem[c*8+6] = rand_next() & 32'hffff_fffc;
            cmd_mem[c*8+7] = rand_next();
        end
        for (int a = NUM_CMDS * 8; a < 64; a++) begin
            cmd_mem[a] = {16'hdead, 8'(a), ~8'(a)};
        end
    endtask

    // Per element a port 0 beat then a port 1 beat, 4 bytes further each element
    task automatic build_model(input int n);
        logic [ADDR_W-1:0] p0;
        logic [ADDR_W-1:0] p1;
        logic [1:0] mask;
        int elems;
        exp_q.delete();
        beats_before[0] = 0;
        for (int c = 0; c < n; c++) begin
            p0 = cmd_mem[c*8+5][ADDR_W-1:0];
            p1 = cmd_mem[c*8+6][ADDR_W-1:0];
            mask = cmd_mem[c*8+2][1:0];
            elems = int'(cmd_mem[c*8][31:24]) ** 2 * int'(cmd_mem[c*8+1][31:16]);
            beats_before[c+1] = beats_before[c] + cmd_beats(c);
            for (int k = 0; k < elems && cmd_beats(c) > 0; k++) begin
                if (mask[0]) begin
                    exp_q.push_back({1'b0, p0 + ADDR_W'(4 * k)});
                end
                if (mask[1]) begin
                    exp_q.push_back({1'b1, p1 + ADDR_W'(4 * k)});
                end
            end
        end
    endtask

    task automatic check_descriptor(input int c);
        logic [31:0] w0;
        logic [31:0] w2;
        w0 = cmd_mem[c*8];
        w2 = cmd_mem[c*8+2];
        check_value(2, stride, w0[7:4], "stride");
        check_value(2, kernel, w0[15:8], "kernel");
        check_value(2, i_side, w0[23:16], "input side");
        check_value(2, i_channel, cmd_mem[c*8+1][15:0], "input channels");
        check_value(2, kernel_size, w2[15:8], "kernel size");
        check_value(2, stride2, w2[31:16], "stride2");
        check_value(2, weight_addr, cmd_mem[c*8+3][ADDR_W-1:0], "weight address");
        check_value(2, data_addr, cmd_mem[c*8+4][ADDR_W-1:0], "data address");
        check_value(2, {p1_pad_body, p1_pad_head, p0_pad_body, p0_pad_head},
                    cmd_mem[c*8+7], "padding bytes");
    endtask

    // Memory answers with gaps and sends stray words while idle
    // Stall is raised at random
    always @(negedge clk) begin
        logic [31:0] r;
        r = rand_next();
        if (cmd_rd_en && r[1:0] != 2'b00) begin
            cmd_we <= 1'b1;
            cmd_word <= cmd_mem[cmd_addr[7:2]];
        end else if (!cmd_rd_en && r[4:2] == 3'b000) begin
            cmd_we <= 1'b1;
            cmd_word <= rand_next();
        end else begin
            cmd_we <= 1'b0;
        end
        res_stall <= (r[9:8] == 2'b00);
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_cmd_addr = '0;
            words_seen = 0;
            cmds_issued = 0;
            beats_written = 0;
            irq_seen = 0;
            stall_pending = 0;
        end else begin
            // Accepted command word
            if (cmd_we && cmd_rd_en) begin
                check_value(1, cmd_addr, exp_cmd_addr, "command read address");
                exp_cmd_addr = exp_cmd_addr + ADDR_W'(4);
                words_seen++;
            end
            // In the issue cycle the descriptor is complete and earlier beats are written
            if (state == csb_pkg::ST_CMD_ISSUE) begin
                check_value(1, words_seen, 8, "words read for one command");
                words_seen = 0;
                if (cmds_issued < run_cmds) begin
                    check_descriptor(cmds_issued);
                    check_value(4, beats_written, beats_before[cmds_issued],
                                "beats written before issue");
                end else begin
                    check_true(4, 1'b0, "more commands issued than programmed");
                end
                cmds_issued++;
            end
            // Engine is valid and out of reset while issuing or writing beats
            if (state == csb_pkg::ST_CMD_ISSUE || res_we) begin
                check_value(6, {engine_valid, engine_reset}, 2'b10,
                            "engine valid and reset while running");
            end else if (state == csb_pkg::ST_IDLE || state == csb_pkg::ST_CMD_GET
                         || state == csb_pkg::ST_FINISH) begin
                check_value(6, {engine_valid, engine_reset}, 2'b01,
                            "engine valid and reset while not running");
            end
            if (stall_pending) begin
                check_value(5, {res_we, res_port, res_addr}, {1'b1, stall_port, stall_addr},
                            "beat held under stall");
            end
            stall_pending = res_we && res_stall;
            stall_port = res_port;
            stall_addr = res_addr;
            // Written beat
            if (res_we && !res_stall) begin
                check_true(4, cmds_issued > 0 && cmd_beats(cmds_issued - 1) > 0,
                           "result write from a command that writes no beats");
                if (exp_q.size() == 0) begin
                    check_true(3, 1'b0, "result beat written when none was expected");
                end else begin
                    check_value(3, {res_port, res_addr}, exp_q.pop_front(), "result beat");
                end
                beats_written++;
            end
            if (irq && !irq_seen) begin
                irq_seen = 1;
                check_value(6, cmds_issued, run_cmds, "commands issued at irq");
                check_value(6, beats_written, beats_before[run_cmds], "beats written at irq");
                check_value(6, state, csb_pkg::ST_FINISH, "state at irq");
            end
        end
    end

    task automatic run_commands(input int n);
        rst = 1'b1;
        op_en = 1'b0;
        cmd_count = 7'(n);
        run_cmds = n;
        build_model(n);
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        op_en = 1'b1;
        // Interrupt marks the end and the watchdog bounds the wait
        while (!irq) @(negedge clk);
        op_en = 1'b0;
        repeat (5) @(negedge clk);
        check_value(1, cmd_addr, ADDR_W'(n * 32), "final command address");
        check_value(6, state, csb_pkg::ST_FINISH, "state after finish");
        check_true(6, irq, "irq low after finish");
        check_true(5, exp_q.size() == 0, "expected beats never written");
    endtask

    initial begin
        int total;
        int all_checks;
        int all_errs;
        rst = 1'b1;
        op_en = 1'b0;
        cmd_count = '0;
        cmd_we = 1'b0;
        cmd_word = '0;
        res_stall = 1'b0;
        rng = 32'h950fa816;
        test_name = '{"read address sequence", "descriptor fields", "beat order",
                      "idle and empty-mask commands", "stall hold", "irq and command count"};
        for (int t = 1; t <= NUM_TESTS; t++) begin
            test_checks[t] = 0;
            test_errs[t] = 0;
        end
        build_commands();
        total = 0;
        for (int c = 0; c < NUM_CMDS; c++) begin
            total += cmd_beats(c) + ((c < 2) ? cmd_beats(c) : 0);
        end
        limit_cycles = total * 10 + 200;
        run_commands(NUM_CMDS);
        // Same commands again with a count of two
        run_commands(2);
        all_checks = 0;
        all_errs = 0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            $display("test %0d %s: %0d checks, %0d errors, %s", t, test_name[t],
                     test_checks[t], test_errs[t], (test_errs[t] == 0) ? "ok" : "FAILED");
            all_checks += test_checks[t];
            all_errs += test_errs[t];
        end
        // Protocol assertion failures count as errors too
        all_errs += dut_i.chk_i.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures", all_checks, all_errs,
                 dut_i.chk_i.fail_count);
        if (all_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog budget comes from the predicted beats of both runs
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the runs did not finish within %0d cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* files.f */
rtl/csb_pkg.sv
rtl/cmd_fetch.sv
rtl/cmd_decode.sv
rtl/csb_ctrl.sv
rtl/result_wr_engine.sv
rtl/csb_top.sv
bench/csb_chk.sv
bench/csb_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module csb_tb -Mdir obj_dir -f files.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned $status, see build.log"
    exit 1
fi

./obj_dir/Vcsb_tb > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned $status, see sim.log"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
